/* include/quirk_table.svh */
`ifndef QUIRK_TABLE_SVH
`define QUIRK_TABLE_SVH

// Titles are zero padded to the full header width
localparam int QUIRK_ENTRIES = 6;

localparam logic [8*TITLE_BYTES-1:0] QUIRK_TITLE [QUIRK_ENTRIES] = '{
	{"ROCKY BOXING"},            // Save type detection breaks the game
	{"DBZ LGCYGOKU"},
	{"IRIDIONII", 24'h000000},
	{"BOMBER MAN", 16'h0000},    // NES classics also need the remap
	{"CASTLEVANIA", 8'h00},
	{"SUPER MARIO2"}
};

localparam quirk_t QUIRK_FLAGS [QUIRK_ENTRIES] = '{
	'{sram_off: 1'b1, memory_remap: 1'b0},
	'{sram_off: 1'b1, memory_remap: 1'b0},
	'{sram_off: 1'b1, memory_remap: 1'b0},
	'{sram_off: 1'b1, memory_remap: 1'b1},
	'{sram_off: 1'b1, memory_remap: 1'b1},
	'{sram_off: 1'b1, memory_remap: 1'b1}
};

`endif

/* logic/bios_word_pack.sv */
module bios_word_pack (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	input  gba_loader_pkg::download_kind_e  kind,
	output gba_loader_pkg::bios_wr_t        bios_wr
);
	import gba_loader_pkg::*;

	logic [IOCTL_DATA_W-1:0] low_half;  // Waits for its partner halfword
	logic                    bios_we;

	assign bios_we = (kind == DL_BIOS) && ioctl.wr;

	always_ff @(posedge clk_sys) begin
		if (bios_we && !ioctl.addr[1]) begin
			low_half <= ioctl.dout;
		end
	end

	// High halfword completes the 32-bit word
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bios_wr.valid <= 1'b0;
		end else begin
			bios_wr.valid <= 1'b0;
			if (bios_we && ioctl.addr[1]) begin
				bios_wr.valid <= 1'b1;
				bios_wr.addr  <= ioctl.addr[13:2];     // Word address
				bios_wr.data  <= {ioctl.dout, low_half};
			end
		end
	end

endmodule

/* logic/cart_info_detect.sv */
module cart_info_detect (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	input  gba_loader_pkg::download_kind_e  kind,
	input  logic                            dl_start,
	input  logic                            dl_end,
	output gba_loader_pkg::cart_info_t      cart_info
);
	import gba_loader_pkg::*;

	localparam logic [71:0] FLASH_SIG = "FLASH1M_V";  // 9 bytes, marks 128K flash saves

	logic [63:0]             history;       // Last 8 bytes seen, newest in the low byte
	logic [IOCTL_ADDR_W-1:0] last_wr_addr;  // Address of the most recent cart write
	logic                    cart_active;   // Current download is a cartridge
	logic                    cart_wr;

	assign cart_wr = (kind == DL_CART) && ioctl.wr;

	// ======================================================================
	// Signature scan
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (dl_start) begin
			history <= '0;  // No match across two files
		end else if (cart_wr) begin
			history <= {history[47:0], ioctl.dout[7:0], ioctl.dout[15:8]};  // Low byte first
		end
		if (cart_wr) begin
			last_wr_addr <= ioctl.addr;
		end
	end

	// ======================================================================
	// Cart info register
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_info   <= '0;
			cart_active <= 1'b0;
		end else begin
			if (dl_start && (kind == DL_CART)) begin
				cart_info.cart_type <= ioctl.index[7:6];
				cart_info.loaded    <= 1'b1;
				cart_info.flash_1m  <= 1'b0;
				cart_active         <= 1'b1;
			end
			if (cart_wr) begin
				// Signature ending at the low byte of this word
				if ({history, ioctl.dout[7:0]} == FLASH_SIG) begin
					cart_info.flash_1m <= 1'b1;
				end
				// Or ending at the high byte
				if ({history[55:0], ioctl.dout[7:0], ioctl.dout[15:8]} == FLASH_SIG) begin
					cart_info.flash_1m <= 1'b1;
				end
			end
			if (dl_end && cart_active) begin
				cart_info.last_addr <= last_wr_addr;  // Used as the max pak address
				cart_active         <= 1'b0;
			end
		end
	end

endmodule

/* logic/cheat_code_pack.sv */
module cheat_code_pack (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	input  gba_loader_pkg::download_kind_e  kind,
	input  logic                            dl_start,
	output gba_loader_pkg::cheat_code_t     cheat_code,
	output logic                            cheat_valid,
	output logic                            cheat_clear
);
	import gba_loader_pkg::*;

	cheat_slot_e slot;     // Halfword position inside the 16-byte code
	logic        code_wr;

	assign slot    = cheat_slot_e'(ioctl.addr[3:1]);
	assign code_wr = (kind == DL_CHEAT) && ioctl.wr && !ioctl.addr[0];

	// ======================================================================
	// Code assembly
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (slot)
				SLOT_FLAGS_LO: cheat_code.flags[15:0]    <= ioctl.dout;
				SLOT_FLAGS_HI: cheat_code.flags[31:16]   <= ioctl.dout;
				SLOT_ADDR_LO:  cheat_code.address[15:0]  <= ioctl.dout;
				SLOT_ADDR_HI:  cheat_code.address[31:16] <= ioctl.dout;
				SLOT_CMP_LO:   cheat_code.compare[15:0]  <= ioctl.dout;
				SLOT_CMP_HI:   cheat_code.compare[31:16] <= ioctl.dout;
				SLOT_REPL_LO:  cheat_code.replace[15:0]  <= ioctl.dout;
				SLOT_REPL_HI:  cheat_code.replace[31:16] <= ioctl.dout;  // Last slot
			endcase
		end
	end

	// Valid and clear strobes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cheat_valid <= 1'b0;
			cheat_clear <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (slot == SLOT_REPL_HI);  // Code complete
			cheat_clear <= dl_start && (kind == DL_CHEAT);     // Drop the old list
		end
	end

endmodule

/* logic/download_classifier.sv */
module download_classifier (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	output gba_loader_pkg::download_kind_e  kind,
	output logic                            dl_start,
	output logic                            dl_end
);
	import gba_loader_pkg::*;

	download_kind_e kind_next;  // Kind decoded from the live host lines

	// Index 0 is BIOS, 255 cheats, everything else a cartridge
	always_comb begin
		if (!ioctl.download) begin
			kind_next = DL_NONE;
		end else if (ioctl.index == BIOS_INDEX) begin
			kind_next = DL_BIOS;
		end else if (ioctl.index == CHEAT_INDEX) begin
			kind_next = DL_CHEAT;
		end else begin
			kind_next = DL_CART;
		end
	end

	// Kind and edge pulses share one register stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			kind     <= DL_NONE;
			dl_start <= 1'b0;
			dl_end   <= 1'b0;
		end else begin
			kind     <= kind_next;
			dl_start <= (kind_next != DL_NONE) && (kind == DL_NONE);  // Rising edge
			dl_end   <= (kind_next == DL_NONE) && (kind != DL_NONE);  // Falling edge
		end
	end

endmodule

/* logic/gba_loader_pkg.sv */
package gba_loader_pkg;

	// ======================================================================
	// Widths and address constants
	// ======================================================================
	localparam int IOCTL_ADDR_W = 27;  // Host byte address
	localparam int IOCTL_DATA_W = 16;  // Host word
	localparam int ROM_ADDR_W   = 26;  // Halfword address on the ROM channel
	localparam int BIOS_ADDR_W  = 12;  // BIOS 32-bit word address
	localparam int TITLE_BYTES  = 12;  // Game title length in the cart header

	// Game ROM sits after flash/EEPROM and large WRAM, in halfwords
	localparam logic [ROM_ADDR_W-1:0] ROM_START_HW = 26'h006_0000;

	localparam logic [IOCTL_ADDR_W-1:0] TITLE_BASE = 27'h0A0;  // Title byte address

	// Download index values from the host
	localparam logic [7:0] BIOS_INDEX  = 8'd0;
	localparam logic [7:0] CHEAT_INDEX = 8'd255;

	// ======================================================================
	// Enums
	// ======================================================================
	typedef enum logic [1:0] {
		DL_NONE,
		DL_BIOS,
		DL_CART,
		DL_CHEAT
	} download_kind_e;

	// Halfword slots of one 16-byte cheat code, in address order
	typedef enum logic [2:0] {
		SLOT_FLAGS_LO,
		SLOT_FLAGS_HI,
		SLOT_ADDR_LO,
		SLOT_ADDR_HI,
		SLOT_CMP_LO,
		SLOT_CMP_HI,
		SLOT_REPL_LO,
		SLOT_REPL_HI
	} cheat_slot_e;

	// ======================================================================
	// Structs
	// ======================================================================
	typedef struct packed {
		logic                    download;  // Download in progress
		logic [7:0]              index;     // Which file kind
		logic [IOCTL_ADDR_W-1:0] addr;      // Byte address
		logic [IOCTL_DATA_W-1:0] dout;
		logic                    wr;        // One cycle per word
	} ioctl_t;

	typedef struct packed {
		logic                    valid;
		logic [ROM_ADDR_W-1:0]   addr;      // Halfword address
		logic [IOCTL_DATA_W-1:0] data;
	} rom_wr_t;

	typedef struct packed {
		logic                   valid;
		logic [BIOS_ADDR_W-1:0] addr;
		logic [31:0]            data;
	} bios_wr_t;

	// Big-endian fields as the loader writes them
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	typedef struct packed {
		logic                    loaded;     // A cart was seen since reset
		logic [1:0]              cart_type;  // Index bits 7:6
		logic                    flash_1m;   // Flash-1M signature found
		logic [IOCTL_ADDR_W-1:0] last_addr;  // Highest written byte address
	} cart_info_t;

	typedef struct packed {
		logic sram_off;
		logic memory_remap;
	} quirk_t;

endpackage

/* logic/gba_loader_top.sv */
module gba_loader_top #(
	parameter int ROM_CREDITS = 4
) (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  gba_loader_pkg::ioctl_t       ioctl,
	output logic                         ioctl_wait,
	output gba_loader_pkg::rom_wr_t      rom_wr,
	input  logic                         mem_credit,
	output gba_loader_pkg::bios_wr_t     bios_wr,
	output gba_loader_pkg::cheat_code_t  cheat_code,
	output logic                         cheat_valid,
	output logic                         cheat_clear,
	output gba_loader_pkg::cart_info_t   cart_info,
	output gba_loader_pkg::quirk_t       quirk
);
	import gba_loader_pkg::*;

	download_kind_e kind;      // Registered kind, shared by all consumers
	logic           dl_start;
	logic           dl_end;

	// ======================================================================
	// Download classification
	// ======================================================================
	download_classifier u_classifier (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.kind     (kind),
		.dl_start (dl_start),
		.dl_end   (dl_end)
	);

	// ======================================================================
	// Cartridge side
	// ======================================================================
	cart_info_detect u_cart_info (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ioctl     (ioctl),
		.kind      (kind),
		.dl_start  (dl_start),
		.dl_end    (dl_end),
		.cart_info (cart_info)
	);

	quirk_detect u_quirk (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.ioctl    (ioctl),
		.kind     (kind),
		.dl_start (dl_start),
		.quirk    (quirk)
	);

	rom_write_credit #(
		.ROM_CREDITS (ROM_CREDITS)
	) u_rom_write (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.ioctl      (ioctl),
		.kind       (kind),
		.rom_wr     (rom_wr),
		.mem_credit (mem_credit),
		.ioctl_wait (ioctl_wait)
	);

	// BIOS and cheat loaders
	bios_word_pack u_bios_pack (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ioctl   (ioctl),
		.kind    (kind),
		.bios_wr (bios_wr)
	);

	cheat_code_pack u_cheat_pack (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl       (ioctl),
		.kind        (kind),
		.dl_start    (dl_start),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

endmodule

/* logic/quirk_detect.sv */
module quirk_detect (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	input  gba_loader_pkg::download_kind_e  kind,
	input  logic                            dl_start,
	output gba_loader_pkg::quirk_t          quirk
);
	import gba_loader_pkg::*;

	`include "quirk_table.svh"

	localparam logic [IOCTL_ADDR_W-1:0] TITLE_END = TITLE_BASE + IOCTL_ADDR_W'(TITLE_BYTES);

	logic [8*TITLE_BYTES-1:0] title;      // First character in the top byte
	logic [3:0]               title_off;  // Byte offset inside the title
	logic [6:0]               title_lsb;  // Bit position of the halfword
	logic                     cart_wr;
	logic                     in_title;
	quirk_t                   match;      // Flags of every matching entry

	assign cart_wr  = (kind == DL_CART) && ioctl.wr;
	assign in_title = (ioctl.addr >= TITLE_BASE) && (ioctl.addr < TITLE_END);

	always_comb begin
		title_off = 4'(ioctl.addr - TITLE_BASE);
		title_lsb = 7'((TITLE_BYTES - 2 - int'(title_off)) * 8);
	end

	// Table lookup, all entries in parallel
	always_comb begin
		match = '0;
		for (int i = 0; i < QUIRK_ENTRIES; i++) begin
			if (title == QUIRK_TITLE[i]) begin
				match = quirk_t'(match | QUIRK_FLAGS[i]);
			end
		end
	end

	// Title bytes arrive low byte first, so swap into string order
	always_ff @(posedge clk_sys) begin
		if (cart_wr && in_title) begin
			title[title_lsb +: 16] <= {ioctl.dout[7:0], ioctl.dout[15:8]};
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			quirk <= '0;
		end else if (dl_start && (kind == DL_CART)) begin
			quirk <= '0;  // New cart, forget the old quirks
		end else if (cart_wr && (ioctl.addr == TITLE_END)) begin
			quirk <= match;  // Title complete once the next halfword shows up
		end
	end

endmodule

/* logic/rom_write_credit.sv */
module rom_write_credit #(
	parameter int ROM_CREDITS = 4
) (
	input  logic                            clk_sys,
	input  logic                            reset,
	input  gba_loader_pkg::ioctl_t          ioctl,
	input  gba_loader_pkg::download_kind_e  kind,
	output gba_loader_pkg::rom_wr_t         rom_wr,
	input  logic                            mem_credit,
	output logic                            ioctl_wait
);
	import gba_loader_pkg::*;

	localparam int CNT_W = $clog2(ROM_CREDITS + 1);

	logic [CNT_W-1:0] credits;       // Writes the memory can still take
	logic [CNT_W-1:0] credits_next;
	logic             cart_wr;

	assign cart_wr = (kind == DL_CART) && ioctl.wr;

	// ======================================================================
	// Relocation onto the game ROM area
	// ======================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_wr.valid <= 1'b0;
		end else begin
			rom_wr.valid <= cart_wr;
			if (cart_wr) begin
				rom_wr.addr <= ROM_START_HW + ioctl.addr[IOCTL_ADDR_W-1:1];  // Byte to halfword
				rom_wr.data <= ioctl.dout;
			end
		end
	end

	// ======================================================================
	// Credit counter
	// ======================================================================
	// Credit is taken when the host word is accepted so the wait flag
	// rises no later than the write that uses the last credit
	always_comb begin
		credits_next = credits - CNT_W'(cart_wr) + CNT_W'(mem_credit);
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			credits    <= CNT_W'(ROM_CREDITS);
			ioctl_wait <= 1'b0;
		end else begin
			credits    <= credits_next;
			ioctl_wait <= (credits_next == '0);  // Hold the host while none left
		end
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_gba_loader -f tb.f -o sim_gba_loader

./obj_dir/sim_gba_loader > sim.log 2>&1
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
	exit 0
fi
exit 1

/* tb.f */
+incdir+include
logic/gba_loader_pkg.sv
logic/download_classifier.sv
logic/cart_info_detect.sv
logic/quirk_detect.sv
logic/bios_word_pack.sv
logic/cheat_code_pack.sv
logic/rom_write_credit.sv
logic/gba_loader_top.sv
testbench/loader_host_driver.sv
testbench/tb_gba_loader.sv

/* testbench/loader_host_driver.sv */
module loader_host_driver (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_wait,
	output gba_loader_pkg::ioctl_t  ioctl,
	output logic                    exp_flash,  // Cart under test carries the signature
	output gba_loader_pkg::quirk_t  exp_quirk,  // Flags the title should select
	output logic                    done
);
	timeunit 1ns;
	timeprecision 100ps;
	import gba_loader_pkg::*;

	integer     seed = 32'h26c4dac9;
	logic [7:0] img [256];  // Byte image of the next cartridge

	// Sends one word and leaves an idle cycle after it so the wait flag is fresh
	task automatic send_word(input logic [26:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		while (ioctl_wait) @(posedge clk_sys);  // Held off by the credit count
		ioctl.addr <= a;
		ioctl.dout <= d;
		ioctl.wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl.wr   <= 1'b0;
	endtask

	task automatic open_download(input logic [7:0] idx);
		@(posedge clk_sys);
		ioctl.index    <= idx;
		ioctl.download <= 1'b1;
		repeat (2) @(posedge clk_sys);  // Setup before the first wr
	endtask

	task automatic close_download();
		repeat (2) @(posedge clk_sys);
		ioctl.download <= 1'b0;
		repeat (4) @(posedge clk_sys);  // Room for the end pulse and result checks
	endtask

	task automatic fill_image();
		for (int i = 0; i < 256; i++) img[i] = 8'($random(seed));
	endtask

	// Image words go out low byte first
	task automatic send_cart(input logic [7:0] idx, input int n_words);
		open_download(idx);
		for (int i = 0; i < n_words; i++) begin
			send_word(27'(2 * i), {img[2*i+1], img[2*i]});
		end
		close_download();
	endtask

	task automatic place_title(input logic [95:0] t);
		for (int i = 0; i < 12; i++) img[8'hA0 + i] = t[95 - 8*i -: 8];
	endtask

	initial begin
		logic [71:0] sig;
		sig       = "FLASH1M_V";
		ioctl     <= '0;
		exp_flash <= 1'b0;
		exp_quirk <= '0;
		done      <= 1'b0;
		@(negedge reset);
		repeat (4) @(posedge clk_sys);

		// ==================================================================
		// BIOS, then a long cart, then flash and title carts
		// ==================================================================
		open_download(BIOS_INDEX);
		for (int i = 0; i < 32; i++) send_word(27'(2 * i), 16'($random(seed)));
		close_download();

		open_download(8'h01);
		for (int i = 0; i < 300; i++) send_word(27'(2 * i), 16'($random(seed)));
		close_download();

		fill_image();
		for (int i = 0; i < 9; i++) img[8'h21 + i] = sig[71 - 8*i -: 8];  // Odd byte offset
		exp_flash <= 1'b1;
		send_cart(8'h40, 48);
		fill_image();
		exp_flash <= 1'b0;
		send_cart(8'h40, 48);

		fill_image();
		place_title({"CASTLEVANIA", 8'h00});
		exp_quirk <= '{sram_off: 1'b1, memory_remap: 1'b1};
		send_cart(8'h02, 88);
		fill_image();
		place_title("NOT A MATCH!");
		exp_quirk <= '0;
		send_cart(8'h02, 88);

		// Three cheat codes of eight halfwords each
		open_download(CHEAT_INDEX);
		for (int c = 0; c < 3; c++) begin
			for (int k = 0; k < 8; k++) send_word(27'(16 * c + 2 * k), 16'($random(seed)));
		end
		close_download();
		done <= 1'b1;
	end

endmodule

/* testbench/tb_gba_loader.sv */
module tb_gba_loader;
	timeunit 1ns;
	timeprecision 100ps;
	import gba_loader_pkg::*;

	localparam int ROM_CREDITS = 4;
	localparam int TOTAL_WORDS = 32 + 300 + 48 + 48 + 88 + 88 + 24;
	localparam int LIMIT_CYCLES = TOTAL_WORDS * 20 + 2000;

	logic        clk_sys;
	logic        reset = 1'b1;
	logic        mem_credit = 1'b0;
	logic        ioctl_wait, cheat_valid, cheat_clear, done, exp_flash;
	ioctl_t      ioctl;
	rom_wr_t     rom_wr;
	bios_wr_t    bios_wr;
	cheat_code_t cheat_code, exp_cheat;
	cart_info_t  cart_info;
	quirk_t      quirk, exp_quirk;

	int          mismatches = 0;
	int          others = 0;
	int          cyc = 0;
	integer      mem_seed = 32'h26c4dac9;
	logic [25:0] exp_addr [1024];  // Expected ROM writes in host order
	logic [15:0] exp_data [1024];
	int          wr_ptr = 0;
	int          rd_ptr = 0;
	int          pending, countdown;
	int          outstanding = 0;  // ROM writes not yet credited back
	logic        prev_dl = 1'b0;
	logic [7:0]  prev_index = 8'd0;
	logic [15:0] bios_lo;
	logic [26:0] exp_last;
	logic        host_cart_wr, host_bios_wr, host_cheat_wr, cheat_rise, cart_fall;

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		repeat (8) @(posedge clk_sys);
		reset <= 1'b0;
	end

	gba_loader_top #(.ROM_CREDITS(ROM_CREDITS)) dut0 (
		.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl), .ioctl_wait(ioctl_wait),
		.rom_wr(rom_wr), .mem_credit(mem_credit), .bios_wr(bios_wr),
		.cheat_code(cheat_code), .cheat_valid(cheat_valid), .cheat_clear(cheat_clear),
		.cart_info(cart_info), .quirk(quirk)
	);

	loader_host_driver host0 (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wait(ioctl_wait), .ioctl(ioctl),
		.exp_flash(exp_flash), .exp_quirk(exp_quirk), .done(done)
	);

	// ======================================================================
	// Host-side view of the stream
	// ======================================================================
	assign host_bios_wr  = ioctl.wr && ioctl.download && (ioctl.index == BIOS_INDEX);
	assign host_cheat_wr = ioctl.wr && ioctl.download && (ioctl.index == CHEAT_INDEX);
	assign host_cart_wr  = ioctl.wr && ioctl.download && !host_bios_wr && !host_cheat_wr;
	assign cheat_rise    = ioctl.download && !prev_dl && (ioctl.index == CHEAT_INDEX);
	assign cart_fall     = !ioctl.download && prev_dl && (prev_index != BIOS_INDEX)
		&& (prev_index != CHEAT_INDEX);

	always @(posedge clk_sys) begin
		cyc        <= cyc + 1;
		prev_dl    <= ioctl.download;
		prev_index <= ioctl.index;
		if (host_bios_wr && !ioctl.addr[1]) bios_lo <= ioctl.dout;
		if (host_cart_wr) exp_last <= ioctl.addr;
		if (host_cheat_wr) begin  // Slot k of field f lands at bit 96-32f+16k
			exp_cheat[96 - 32*int'(ioctl.addr[3:2]) + 16*int'(ioctl.addr[1]) +: 16] <= ioctl.dout;
		end
	end

	// Memory model returns one credit per write after 0 to 5 idle cycles
	always @(posedge clk_sys) begin
		if (reset) begin
			mem_credit  <= 1'b0;
			pending     = 0;
			countdown   = 0;
			outstanding <= 0;
		end else begin
			mem_credit <= 1'b0;
			if (host_cart_wr) begin
				exp_addr[wr_ptr % 1024] <= ROM_START_HW + 26'(ioctl.addr >> 1);
				exp_data[wr_ptr % 1024] <= ioctl.dout;
				wr_ptr <= wr_ptr + 1;
			end
			if (rom_wr.valid) rd_ptr <= rd_ptr + 1;
			outstanding <= outstanding + int'(rom_wr.valid) - int'(mem_credit);
			pending = pending + int'(rom_wr.valid);
			if (pending > 0) begin
				if (countdown == 0) begin
					mem_credit <= 1'b1;
					pending    = pending - 1;
					countdown  = int'($unsigned($random(mem_seed)) % 6);
				end else begin
					countdown = countdown - 1;
				end
			end
		end
	end

	// ======================================================================
	// Checks
	// ======================================================================
	a_reset_quiet: assert property (@(posedge clk_sys) (cyc >= 2 && cyc <= 12) |->
		!rom_wr.valid && !bios_wr.valid && !cheat_valid && !cheat_clear && !ioctl_wait
		&& quirk == '0 && cart_info == '0)
		else begin
			others++;
			$display("outputs not quiet around reset at %0t", $time);
		end

	a_rom_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr.valid == $past(host_cart_wr))
		else begin
			others++;
			$display("rom_wr missing or extra at %0t", $time);
		end
	a_rom_addr: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr.valid |-> rom_wr.addr == exp_addr[rd_ptr % 1024])
		else begin
			mismatches++;
			$display("mismatch at %0t: rom_wr.addr expected %h actual %h", $time,
				$sampled(exp_addr[rd_ptr % 1024]), $sampled(rom_wr.addr));
		end
	a_rom_data: assert property (@(posedge clk_sys) disable iff (reset)
		rom_wr.valid |-> rom_wr.data == exp_data[rd_ptr % 1024])
		else begin
			mismatches++;
			$display("mismatch at %0t: rom_wr.data expected %h actual %h", $time,
				$sampled(exp_data[rd_ptr % 1024]), $sampled(rom_wr.data));
		end
	a_credit_bound: assert property (@(posedge clk_sys) disable iff (reset)
		outstanding <= ROM_CREDITS)
		else begin
			others++;
			$display("more ROM writes outstanding than credits");
		end
	a_host_wait: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl.wr |-> !ioctl_wait)
		else begin
			others++;
			$display("host wrote while ioctl_wait was high");
		end

	a_bios_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr.valid == $past(host_bios_wr && ioctl.addr[1]))
		else begin
			others++;
			$display("bios_wr missing or extra at %0t", $time);
		end
	a_bios_addr: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr.valid |-> bios_wr.addr == $past(ioctl.addr[13:2]))
		else begin
			mismatches++;
			$display("mismatch at %0t: bios_wr.addr expected %h actual %h", $time,
				$past(ioctl.addr[13:2]), $sampled(bios_wr.addr));
		end
	a_bios_data: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr.valid |-> bios_wr.data == {$past(ioctl.dout), $past(bios_lo)})
		else begin
			mismatches++;
			$display("mismatch at %0t: bios_wr.data expected %h actual %h", $time,
				{$past(ioctl.dout), $past(bios_lo)}, $sampled(bios_wr.data));
		end

	a_cheat_clear: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_clear == $past(cheat_rise, 2))
		else begin
			others++;
			$display("cheat_clear missing or extra at %0t", $time);
		end
	a_cheat_valid: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid == $past(host_cheat_wr && ioctl.addr[3:0] == 4'hE))
		else begin
			others++;
			$display("cheat_valid missing or extra at %0t", $time);
		end
	a_cheat_code: assert property (@(posedge clk_sys) disable iff (reset)
		cheat_valid |-> cheat_code == exp_cheat)
		else begin
			mismatches++;
			$display("mismatch at %0t: cheat_code expected %h actual %h", $time,
				$sampled(exp_cheat), $sampled(cheat_code));
		end

	// Cart info settles 3 sampled cycles after download falls
	a_cart_info: assert property (@(posedge clk_sys) disable iff (reset)
		$past(cart_fall, 3) |-> cart_info.loaded && cart_info.flash_1m == exp_flash
		&& cart_info.cart_type == $past(prev_index[7:6], 3) && cart_info.last_addr == exp_last)
		else begin
			mismatches++;
			$display("mismatch at %0t: cart_info expected %b/%h/%b/%h actual %h", $time,
				1'b1, $past(prev_index[7:6], 3), $sampled(exp_flash), $sampled(exp_last),
				$sampled(cart_info));
		end
	a_quirk: assert property (@(posedge clk_sys) disable iff (reset)
		$past(host_cart_wr && ioctl.addr == 27'h0AC) |-> quirk == exp_quirk)
		else begin
			mismatches++;
			$display("mismatch at %0t: quirk expected %b actual %b", $time,
				$sampled(exp_quirk), $sampled(quirk));
		end

	// ======================================================================
	// End of run
	// ======================================================================
	initial begin
		wait (done === 1'b1);
		repeat (10) @(posedge clk_sys);
		$display("errors: %0d mismatches, %0d other failures", mismatches, others);
		if (mismatches + others == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

	initial begin
		#(LIMIT_CYCLES * 4);
		$display("timeout: the downloads did not finish in %0d cycles", LIMIT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule
